// ==== compile.f ====
+incdir+design
design/ram_pkg.sv
design/mem_req_pkg.sv
design/sched_buffer_if.sv
design/wrap_counter.sv
design/word_ram.sv
design/request_buffer.sv
design/ram_sequencer.sv
design/mem_scheduler_top.sv
testbench/mem_scheduler_tb.sv

// ==== design/mem_req_pkg.sv ====
`default_nettype none

`include "sched_config.svh"

package mem_req_pkg;

    localparam int PTR_W = $clog2(`SCHED_DEPTH);

    // one buffered request.
    // data only matters for writes.
    typedef struct packed {
        logic               is_write;
        ram_pkg::ram_addr_t addr;
        ram_pkg::ram_word_t data;
    } req_entry_t;

    typedef logic [PTR_W-1:0] buf_ptr_t;

    // extra bit so a full buffer can be told from an empty one.
    typedef logic [PTR_W:0] buf_count_t;

endpackage

`default_nettype wire

// ==== design/mem_scheduler_top.sv ====
`default_nettype none

`include "sched_config.svh"

module mem_scheduler_top (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     req_valid,
    input  logic                     req_write,
    input  logic [`SCHED_ADDR_W-1:0] req_addr,
    input  logic [`SCHED_DATA_W-1:0] req_data,
    input  logic                     flush,
    input  logic                     drain_en,
    output logic                     resp_valid,
    output logic                     resp_write,
    output logic [`SCHED_ADDR_W-1:0] resp_addr,
    output logic [`SCHED_DATA_W-1:0] resp_data,
    output logic                     full
);
    import ram_pkg::*;
    import mem_req_pkg::*;

    req_entry_t push_entry;

    logic      ram_en;
    logic      ram_we;
    ram_addr_t ram_addr;
    ram_word_t ram_wdata;
    ram_word_t ram_rdata;

    sched_buffer_if sq_if ();

    assign push_entry.is_write = req_write;
    assign push_entry.addr     = req_addr;
    assign push_entry.data     = req_data;

    request_buffer i_request_buffer (
        .CLK        (CLK),
        .nRST       (nRST),
        .push       (req_valid),
        .push_entry (push_entry),
        .flush      (flush),
        .full       (full),
        .sq         (sq_if.buffer)
    );

    ram_sequencer i_ram_sequencer (
        .CLK        (CLK),
        .nRST       (nRST),
        .drain_en   (drain_en),
        .sq         (sq_if.sequencer),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .resp_valid (resp_valid),
        .resp_write (resp_write),
        .resp_addr  (resp_addr),
        .resp_data  (resp_data)
    );

    word_ram i_word_ram (
        .CLK   (CLK),
        .nRST  (nRST),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== design/ram_pkg.sv ====
`default_nettype none

`include "sched_config.svh"

package ram_pkg;

    typedef logic [`SCHED_ADDR_W-1:0] ram_addr_t;

    typedef logic [`SCHED_DATA_W-1:0] ram_word_t;

    // one request per pass through all three states.
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_ISSUE = 2'd1,
        SEQ_WAIT  = 2'd2
    } seq_state_t;

endpackage

`default_nettype wire

// ==== design/ram_sequencer.sv ====
`default_nettype none

module ram_sequencer (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               drain_en,
    sched_buffer_if.sequencer  sq,
    output logic               ram_en,
    output logic               ram_we,
    output ram_pkg::ram_addr_t ram_addr,
    output ram_pkg::ram_word_t ram_wdata,
    input  ram_pkg::ram_word_t ram_rdata,
    output logic               resp_valid,
    output logic               resp_write,
    output ram_pkg::ram_addr_t resp_addr,
    output ram_pkg::ram_word_t resp_data
);
    import ram_pkg::*;
    import mem_req_pkg::*;

    seq_state_t state;
    seq_state_t next_state;

    // request in flight from idle until its response.
    req_entry_t cur;

    logic take;

    assign take = (state == SEQ_IDLE) && !sq.empty && drain_en;
    assign sq.request_done = take;

    always_comb begin
        next_state = state;
        case (state)
            SEQ_IDLE: begin
                if (take) begin
                    next_state = SEQ_ISSUE;
                end
            end
            SEQ_ISSUE: next_state = SEQ_WAIT;
            SEQ_WAIT:  next_state = SEQ_IDLE;
            default:   next_state = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= SEQ_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            cur <= sq.head;
        end
    end

    // ram access.
    assign ram_en    = (state == SEQ_ISSUE);
    assign ram_we    = ram_en && cur.is_write;
    assign ram_addr  = cur.addr;
    assign ram_wdata = cur.data;

    // read word is registered in the ram, so it lands in wait.
    assign resp_valid = (state == SEQ_WAIT);
    assign resp_write = cur.is_write;
    assign resp_addr  = cur.addr;
    assign resp_data  = cur.is_write ? cur.data : ram_rdata;

endmodule

`default_nettype wire

// ==== design/request_buffer.sv ====
`default_nettype none

`include "sched_config.svh"

module request_buffer (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   push,
    input  mem_req_pkg::req_entry_t push_entry,
    input  logic                   flush,
    output logic                   full,
    sched_buffer_if.buffer         sq
);
    import mem_req_pkg::*;

    localparam buf_ptr_t   LAST_PTR = buf_ptr_t'(`SCHED_DEPTH - 1);
    localparam buf_count_t MAX_COUNT = buf_count_t'(`SCHED_DEPTH);

    req_entry_t entries [`SCHED_DEPTH];

    buf_ptr_t   wptr;
    buf_ptr_t   rptr;
    buf_count_t count;
    buf_count_t next_count;

    logic push_ok;
    logic pop_ok;

    // a strobe in the flush cycle is thrown away with the rest.
    assign push_ok = push && !full && !flush;
    assign pop_ok  = sq.request_done && !sq.empty;

    wrap_counter #(
        .NBITS($bits(buf_ptr_t))
    ) write_count (
        .CLK          (CLK),
        .nRST         (nRST),
        .clear        (flush),
        .count_enable (push_ok),
        .wrap_val     (LAST_PTR),
        .count_out    (wptr)
    );

    wrap_counter #(
        .NBITS($bits(buf_ptr_t))
    ) read_count (
        .CLK          (CLK),
        .nRST         (nRST),
        .clear        (flush),
        .count_enable (pop_ok),
        .wrap_val     (LAST_PTR),
        .count_out    (rptr)
    );

    always_ff @(posedge CLK) begin
        if (push_ok) begin
            entries[wptr] <= push_entry;
        end
    end

    // push and pop in the same cycle leave occupancy alone.
    always_comb begin
        next_count = count;
        if (flush) begin
            next_count = '0;
        end else begin
            case ({push_ok, pop_ok})
                2'b10: next_count = count + 1'b1;
                2'b01: next_count = count - 1'b1;
                default: next_count = count;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else begin
            count <= next_count;
        end
    end

    assign full     = (count == MAX_COUNT);
    assign sq.empty = (count == '0);
    assign sq.head  = entries[rptr];

endmodule

`default_nettype wire

// ==== design/sched_buffer_if.sv ====
`default_nettype none

interface sched_buffer_if;
    import mem_req_pkg::*;

    // oldest entry still waiting.
    req_entry_t head;
    logic       empty;

    // retires head at the edge it is seen.
    logic       request_done;

    modport buffer (
        output head,
        output empty,
        input  request_done
    );

    modport sequencer (
        input  head,
        input  empty,
        output request_done
    );

endinterface

`default_nettype wire

// ==== design/sched_config.svh ====
`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// ram address width for 64 words.
`define SCHED_ADDR_W 6

// data word width.
`define SCHED_DATA_W 32

// power of two number of request buffer entries.
`define SCHED_DEPTH 16

`endif

// ==== design/word_ram.sv ====
`default_nettype none

`include "sched_config.svh"

module word_ram (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               en,
    input  logic               we,
    input  ram_pkg::ram_addr_t addr,
    input  ram_pkg::ram_word_t wdata,
    output ram_pkg::ram_word_t rdata
);
    import ram_pkg::*;

    localparam int WORDS = 2 ** `SCHED_ADDR_W;

    ram_word_t mem [WORDS];

    // unwritten words read back as zero.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (en && we) begin
            mem[addr] <= wdata;
        end
    end

    // read word shows up one edge after en.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rdata <= '0;
        end else if (en && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== design/wrap_counter.sv ====
`default_nettype none

module wrap_counter #(
    parameter int NBITS = 4
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             clear,
    input  logic             count_enable,
    input  logic [NBITS-1:0] wrap_val,
    output logic [NBITS-1:0] count_out
);

    logic [NBITS-1:0] next_count;

    always_comb begin
        next_count = count_out;
        if (clear) begin
            next_count = '0;
        end else if (count_enable) begin
            if (count_out == wrap_val) begin
                next_count = '0;
            end else begin
                next_count = count_out + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count_out <= '0;
        end else begin
            count_out <= next_count;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing -f compile.f --top-module mem_scheduler_tb \
    -o Vmem_scheduler_tb \
    && ./obj_dir/Vmem_scheduler_tb \
    || { echo "build or simulation failed"; exit 1; }

// ==== testbench/mem_scheduler_tb.sv ====
`default_nettype none

`include "sched_config.svh"

module mem_scheduler_tb;
    import ram_pkg::*;
    import mem_req_pkg::*;

    logic      CLK;
    logic      nRST;
    logic      req_valid;
    logic      req_write;
    ram_addr_t req_addr;
    ram_word_t req_data;
    logic      flush;
    logic      drain_en;
    logic      resp_valid;
    logic      resp_write;
    ram_addr_t resp_addr;
    ram_word_t resp_data;
    logic      full;

    // accepted requests not yet answered with the oldest first.
    req_entry_t exp_q[$];
    ram_word_t  model_ram [2 ** `SCHED_ADDR_W];
    logic [15:0] lfsr_state;

    mem_scheduler_top i_mem_scheduler_top (
        .CLK        (CLK),
        .nRST       (nRST),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_data   (req_data),
        .flush      (flush),
        .drain_en   (drain_en),
        .resp_valid (resp_valid),
        .resp_write (resp_write),
        .resp_addr  (resp_addr),
        .resp_data  (resp_data),
        .full       (full)
    );

    always #4 CLK = ~CLK;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // expected response word for requests taken in order.
    function automatic ram_word_t predict_response(input req_entry_t e);
        if (e.is_write) begin
            model_ram[e.addr] = e.data;
            return e.data;
        end else begin
            return model_ram[e.addr];
        end
    endfunction

    task automatic fail_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        fail_run();
    endtask

    task automatic report_error(input string msg);
        $display("error: %s", msg);
        fail_run();
    endtask

    task automatic check_flag(input string what, input logic got, input logic want);
        if (got !== want) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, got, want));
        end
    endtask

    // data is left to check_word.
    task automatic check_entry(input req_entry_t got, input req_entry_t want);
        if (got.is_write !== want.is_write || got.addr !== want.addr) begin
            report_mismatch($sformatf("response write=%b addr=%0d, expected write=%b addr=%0d",
                got.is_write, got.addr, want.is_write, want.addr));
        end
    endtask

    task automatic check_word(input string what, input ram_word_t got, input ram_word_t want);
        if (got !== want) begin
            report_mismatch($sformatf("%s is %h, expected %h", what, got, want));
        end
    endtask

    task automatic send_req(input logic is_write, input ram_addr_t addr,
                            input ram_word_t data, input logic with_flush);
        req_entry_t e;
        @(negedge CLK);
        // exact with drain off and never near full with drain on.
        check_flag("full", full, exp_q.size() == `SCHED_DEPTH);
        req_valid = 1'b1;
        req_write = is_write;
        req_addr  = addr;
        req_data  = data;
        flush     = with_flush;
        e.is_write = is_write;
        e.addr     = addr;
        e.data     = data;
        if (with_flush) begin
            exp_q.delete();
        end else if (exp_q.size() < `SCHED_DEPTH) begin
            exp_q.push_back(e);
        end
    endtask

    task automatic send_random();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] d;
        take_bits(1, w);
        take_bits(4, a);
        take_bits(32, d);
        send_req(w[0], ram_addr_t'(a[3:0]), d, 1'b0);
    endtask

    task automatic idle_cycle();
        @(negedge CLK);
        req_valid = 1'b0;
        flush     = 1'b0;
    endtask

    task automatic set_drain(input logic v);
        idle_cycle();
        drain_en = v;
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n >= limit) begin
                report_error("timed out waiting for responses");
            end
            @(negedge CLK);
            n++;
        end
    endtask

    // a response here has no entry and trips the compare process.
    task automatic wait_quiet(input int cycles);
        int n;
        n = 0;
        while (n < cycles) begin
            @(negedge CLK);
            n++;
        end
    endtask

    // compare process.
    initial begin
        req_entry_t seen;
        req_entry_t want;
        for (int i = 0; i < 2 ** `SCHED_ADDR_W; i++) begin
            model_ram[i] = '0;
        end
        forever begin
            @(negedge CLK);
            if (nRST && resp_valid) begin
                if (exp_q.size() == 0) begin
                    report_error("response arrived with no request pending");
                end else begin
                    want = exp_q.pop_front();
                    seen.is_write = resp_write;
                    seen.addr     = resp_addr;
                    seen.data     = resp_data;
                    check_entry(seen, want);
                    check_word("response data", resp_data, predict_response(want));
                end
            end
        end
    end

    initial begin
        logic [31:0] d;
        CLK        = 1'b0;
        nRST       = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_data   = '0;
        flush      = 1'b0;
        drain_en   = 1'b0;
        lfsr_state = 16'd26;
        repeat (10) @(negedge CLK);
        nRST = 1'b1;

        // unwritten word reads as zero.
        set_drain(1'b1);
        check_flag("full after reset", full, 1'b0);
        send_req(1'b0, ram_addr_t'(37), '0, 1'b0);
        idle_cycle();
        wait_drained(20);

        // random mix with the queue kept short.
        for (int i = 0; i < 200; i++) begin
            if (exp_q.size() < 4) begin
                send_random();
            end else begin
                idle_cycle();
            end
        end
        idle_cycle();
        wait_drained(100);

        // fill past full with the sequencer paused.
        set_drain(1'b0);
        for (int i = 0; i < `SCHED_DEPTH + 4; i++) begin
            send_random();
        end
        idle_cycle();
        check_flag("full with buffer filled", full, 1'b1);
        set_drain(1'b1);
        wait_drained(4 * `SCHED_DEPTH + 20);
        wait_quiet(40);

        // flush drops everything including the strobe in the flush cycle.
        set_drain(1'b0);
        for (int i = 0; i < 6; i++) begin
            send_req(1'b1, ram_addr_t'(40 + i), 32'hA500_0000 + i, 1'b0);
        end
        send_req(1'b1, ram_addr_t'(46), 32'hDEAD_BEEF, 1'b1);
        set_drain(1'b1);
        wait_quiet(40);
        for (int i = 0; i < 7; i++) begin
            send_req(1'b0, ram_addr_t'(40 + i), '0, 1'b0);
        end
        send_req(1'b1, ram_addr_t'(40), 32'h1234_5678, 1'b0);
        send_req(1'b0, ram_addr_t'(40), '0, 1'b0);
        idle_cycle();
        wait_drained(100);

        // back to back writes then reads of the same words.
        for (int i = 0; i < 6; i++) begin
            take_bits(32, d);
            send_req(1'b1, ram_addr_t'(50 + i), d, 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            send_req(1'b0, ram_addr_t'(50 + i), '0, 1'b0);
        end
        idle_cycle();
        wait_drained(100);
        wait_quiet(10);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
